// File: logic/rx_bus_writer.sv
module rx_bus_writer #(
	parameter int BUF_DWORDS = 512,
	parameter int MAX_BURST = 256
)(
	input  logic aclk,
	input  logic arst_n_i,
	input  rx_pkg::wr_cmd_t cmd_i,
	input  logic cmd_valid_i,
	output logic cmd_ready_o,
	input  rx_pkg::dword_t stat_word_i,
	output logic [$clog2(BUF_DWORDS)-1:0] rd_idx_o,
	input  rx_pkg::dword_t rd_data_i,
	output logic done_o,
	output rx_pkg::wr_addr_t aw_o,
	output logic aw_valid_o,
	input  logic aw_ready_i,
	output rx_pkg::wr_data_t w_o,
	output logic w_valid_o,
	input  logic w_ready_i,
	input  logic bvalid_i,
	output logic bready_o
);
	import rx_pkg::*;

	localparam int IDX_W = $clog2(BUF_DWORDS);
	localparam int BEAT_W = IDX_W + 1;

	typedef logic [BEAT_W-1:0] beat_cnt_t;

	logic busy;
	logic from_buf;
	strb_t last_strb;
	beat_cnt_t cmd_beats;
	beat_cnt_t cmd_bursts;
	beat_cnt_t aw_left;
	beat_cnt_t w_left;
	beat_cnt_t rd_cnt;
	beat_cnt_t rd_cnt_nx;
	beat_cnt_t aw_credit; // Bursts addressed but not yet fully sent
	beat_cnt_t resp_left;
	burst_len_t w_beat;
	logic w_full;
	logic beat_last;
	logic cmd_go;
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic load;

	function automatic beat_cnt_t clip(input beat_cnt_t left);
		return (left > MAX_BURST) ? beat_cnt_t'(MAX_BURST) : left;
	endfunction

	assign cmd_beats = beat_cnt_t'((17'(cmd_i.bytes) + 17'd3) >> 2);
	assign cmd_bursts = beat_cnt_t'((cmd_beats + MAX_BURST - 1) / MAX_BURST);
	assign cmd_ready_o = !busy;
	assign cmd_go = cmd_valid_i && !busy;
	assign aw_hs = aw_valid_o && aw_ready_i;
	assign w_valid_o = w_full && (aw_credit != '0); // W never runs ahead of AW
	assign w_hs = w_valid_o && w_ready_i;
	assign bready_o = busy;
	assign b_hs = bvalid_i && busy;
	assign load = (w_left != '0) && (!w_full || w_hs);
	assign beat_last = (w_left == 1) || (w_beat == burst_len_t'(MAX_BURST - 1));

	// Read index runs one cycle ahead of the RAM output
	assign rd_cnt_nx = cmd_go ? '0 : (load ? rd_cnt + 1'b1 : rd_cnt);
	assign rd_idx_o = rd_cnt_nx[IDX_W-1:0];

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			busy <= 1'b0;
			from_buf <= 1'b0;
			last_strb <= '1;
			resp_left <= '0;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			if (cmd_go)
			begin
				busy <= 1'b1;
				from_buf <= cmd_i.from_buf;
				last_strb <= (cmd_i.bytes[1:0] == 2'd0) ? '1 :
					strb_t'((1 << cmd_i.bytes[1:0]) - 1);
				resp_left <= cmd_bursts;
			end
			else if (b_hs)
			begin
				resp_left <= resp_left - 1'b1;
				if (resp_left == 1)
				begin
					busy <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			aw_valid_o <= 1'b0;
			aw_left <= '0;
			aw_o <= '0;
		end
		else if (cmd_go)
		begin
			aw_valid_o <= 1'b1;
			aw_o.addr <= cmd_i.addr;
			aw_o.len <= burst_len_t'(clip(cmd_beats) - 1'b1);
			aw_left <= cmd_beats - clip(cmd_beats);
		end
		else if (aw_hs)
		begin
			aw_o.addr <= aw_o.addr + (host_addr_t'(aw_o.len) + 1) * (DATA_W / 8);
			aw_o.len <= burst_len_t'(clip(aw_left) - 1'b1);
			aw_left <= aw_left - clip(aw_left);
			aw_valid_o <= (aw_left != '0);
		end
	end

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			w_full <= 1'b0;
			w_left <= '0;
			rd_cnt <= '0;
			w_beat <= '0;
			aw_credit <= '0;
		end
		else
		begin
			rd_cnt <= rd_cnt_nx;
			aw_credit <= aw_credit + beat_cnt_t'(aw_hs) - beat_cnt_t'(w_hs && w_o.last);
			if (cmd_go)
			begin
				w_left <= cmd_beats;
				w_beat <= '0;
			end
			else if (load)
			begin
				w_left <= w_left - 1'b1;
				w_full <= 1'b1;
				w_beat <= beat_last ? '0 : w_beat + 1'b1;
			end
			else if (w_hs)
				w_full <= 1'b0;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (load)
		begin
			w_o.data <= from_buf ? rd_data_i : stat_word_i;
			w_o.strb <= (w_left == 1) ? last_strb : '1; // Tail bytes only
			w_o.last <= beat_last;
		end
	end

endmodule

// File: logic/rx_engine.sv
module rx_engine (
	input  logic aclk,
	input  logic arst_n_i,
	input  rx_pkg::rx_cfg_t cfg_i,
	input  logic slot_avail_i,
	input  rx_pkg::ring_idx_t head_i,
	output logic recv_en_o,
	input  logic frame_done_i,
	input  rx_pkg::byte_cnt_t frame_bytes_i,
	output rx_pkg::wr_cmd_t cmd_o,
	output logic cmd_valid_o,
	input  logic cmd_ready_i,
	output rx_pkg::dword_t stat_word_o,
	input  logic wr_done_i,
	output logic adv_o
);
	import rx_pkg::*;

	rx_state_e state;
	logic issued; // Command of this state accepted by the writer
	logic [3:0] bsize_sh;
	byte_cnt_t buf_bytes;
	byte_cnt_t wr_bytes;
	logic trunc;
	host_addr_t data_addr;
	host_addr_t stat_addr;

	// Buffer size is 2048 >> bsize
	assign bsize_sh = 4'd11 - {2'b00, cfg_i.bsize};
	assign buf_bytes = byte_cnt_t'(1) << bsize_sh;
	assign trunc = (frame_bytes_i > buf_bytes);
	assign wr_bytes = trunc ? buf_bytes : frame_bytes_i;
	assign data_addr = cfg_i.buf_base + (host_addr_t'(head_i) << bsize_sh);
	assign stat_addr = cfg_i.rdba + host_addr_t'(head_i) * DESC_BYTES + STAT_OFFSET;

	assign stat_word_o = {7'b0, trunc, 6'b0, 1'b1, 1'b1, wr_bytes}; // EOP and DD set

	assign recv_en_o = (state == ST_RECV);
	assign adv_o = (state == ST_ADV);
	assign cmd_valid_o = ((state == ST_DATA) || (state == ST_STAT)) && !issued;

	always_comb
	begin
		cmd_o.from_buf = (state == ST_DATA);
		cmd_o.addr = (state == ST_STAT) ? stat_addr : data_addr;
		cmd_o.bytes = (state == ST_STAT) ? byte_cnt_t'(DATA_W / 8) : wr_bytes;
	end

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state <= ST_IDLE;
			issued <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (cfg_i.en && slot_avail_i)
						state <= ST_RECV;
				ST_RECV:
					if (frame_done_i)
						state <= ST_DATA;
				ST_DATA, ST_STAT:
				begin
					if (cmd_valid_o && cmd_ready_i)
						issued <= 1'b1;
					if (wr_done_i)
					begin
						issued <= 1'b0;
						state <= (state == ST_DATA) ? ST_STAT : ST_ADV;
					end
				end
				ST_ADV:
					state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: logic/rx_frame_buf.sv
module rx_frame_buf #(
	parameter int BUF_DWORDS = 512
)(
	input  logic aclk,
	input  logic arst_n_i,
	input  rx_pkg::mac_beat_t beat_i,
	input  logic beat_valid_i,
	output logic beat_ready_o,
	input  logic recv_en_i,
	output logic frame_done_o,
	output rx_pkg::byte_cnt_t frame_bytes_o,
	input  logic [$clog2(BUF_DWORDS)-1:0] rd_idx_i,
	output rx_pkg::dword_t rd_data_o
);
	import rx_pkg::*;

	localparam int IDX_W = $clog2(BUF_DWORDS);

	dword_t mem [BUF_DWORDS];
	logic [15:0] wr_idx; // Keeps counting past the buffer end
	logic [15:0] cur_idx;
	byte_cnt_t cur_bytes;
	logic restart;
	logic beat_hs;

	function automatic byte_cnt_t kept_bytes(input strb_t keep);
		byte_cnt_t n;
		n = '0;
		for (int i = 0; i < $bits(strb_t); i++)
			n = n + byte_cnt_t'(keep[i]);
		return n;
	endfunction

	assign beat_ready_o = recv_en_i;
	assign beat_hs = beat_valid_i && recv_en_i;
	assign frame_done_o = beat_hs && beat_i.last;

	// A new frame starts over at index zero
	assign cur_idx = restart ? '0 : wr_idx;
	assign cur_bytes = restart ? '0 : frame_bytes_o;

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			wr_idx <= '0;
			frame_bytes_o <= '0;
			restart <= 1'b0;
		end
		else if (beat_hs)
		begin
			wr_idx <= cur_idx + 16'd1;
			frame_bytes_o <= cur_bytes + kept_bytes(beat_i.keep);
			restart <= beat_i.last;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (beat_hs && (cur_idx < BUF_DWORDS))
			mem[cur_idx[IDX_W-1:0]] <= beat_i.data;
		rd_data_o <= mem[rd_idx_i];
	end

endmodule

// File: logic/rx_intr_timer.sv
module rx_intr_timer #(
	parameter int TICK_CYCLES = 128
)(
	input  logic aclk,
	input  logic arst_n_i,
	input  logic [15:0] rdtr_i,
	input  logic start_i,
	output logic rxt0_req_o
);

	localparam int PRE_W = $clog2(TICK_CYCLES + 1);

	logic armed;
	logic [PRE_W-1:0] pre_cnt; // Clocks within one delay unit
	logic [15:0] units;

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			armed <= 1'b0;
			pre_cnt <= '0;
			units <= '0;
			rxt0_req_o <= 1'b0;
		end
		else
		begin
			rxt0_req_o <= 1'b0;
			if (start_i)
			begin
				// Every head advance restarts the delay
				armed <= 1'b1;
				pre_cnt <= '0;
				units <= rdtr_i;
			end
			else if (armed)
			begin
				if (units == '0)
				begin
					armed <= 1'b0;
					rxt0_req_o <= 1'b1;
				end
				else if (pre_cnt == PRE_W'(TICK_CYCLES - 1))
				begin
					pre_cnt <= '0;
					units <= units - 16'd1;
				end
				else
					pre_cnt <= pre_cnt + 1'b1;
			end
		end
	end

endmodule

// File: logic/rx_path.sv
module rx_path #(
	parameter int BUF_DWORDS = 512,
	parameter int MAX_BURST = 256,
	parameter int TICK_CYCLES = 128
)(
	input  logic aclk,
	input  logic arst_n_i,

	input  rx_pkg::mac_beat_t mac_s_i,
	input  logic mac_s_tvalid_i,
	output logic mac_s_tready_o,

	input  rx_pkg::rx_cfg_t cfg_i,
	input  rx_pkg::ring_idx_t rdh_i,
	input  logic rdh_set_i,
	input  rx_pkg::ring_idx_t rdt_i,
	input  logic rdt_set_i,
	output rx_pkg::ring_idx_t rdh_fb_o,

	// Host write bus
	output rx_pkg::wr_addr_t axi_m_aw_o,
	output logic axi_m_awvalid_o,
	input  logic axi_m_awready_i,
	output rx_pkg::wr_data_t axi_m_w_o,
	output logic axi_m_wvalid_o,
	input  logic axi_m_wready_i,
	input  logic [1:0] axi_m_bresp_i, // Response code treated as OKAY
	input  logic axi_m_bvalid_i,
	output logic axi_m_bready_o,

	output logic rxt0_req_o,
	output logic rxdmt0_req_o
);
	import rx_pkg::*;

	logic recv_en;
	logic frame_done;
	byte_cnt_t frame_bytes;
	logic [$clog2(BUF_DWORDS)-1:0] rd_idx;
	dword_t rd_data;
	wr_cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	dword_t stat_word;
	logic wr_done;
	logic adv;
	logic slot_avail;

	rx_ring_ctrl rx_ring_ctrl_i (
		.aclk(aclk),
		.arst_n_i(arst_n_i),
		.cfg_i(cfg_i),
		.rdh_i(rdh_i),
		.rdt_i(rdt_i),
		.rdh_set_i(rdh_set_i),
		.rdt_set_i(rdt_set_i),
		.adv_i(adv),
		.slot_avail_o(slot_avail),
		.head_o(rdh_fb_o),
		.rxdmt0_req_o(rxdmt0_req_o)
	);

	rx_frame_buf #(
		.BUF_DWORDS(BUF_DWORDS)
	) rx_frame_buf_i (
		.aclk(aclk),
		.arst_n_i(arst_n_i),
		.beat_i(mac_s_i),
		.beat_valid_i(mac_s_tvalid_i),
		.beat_ready_o(mac_s_tready_o),
		.recv_en_i(recv_en),
		.frame_done_o(frame_done),
		.frame_bytes_o(frame_bytes),
		.rd_idx_i(rd_idx),
		.rd_data_o(rd_data)
	);

	// Receiver state machine
	rx_engine rx_engine_i (
		.aclk(aclk),
		.arst_n_i(arst_n_i),
		.cfg_i(cfg_i),
		.slot_avail_i(slot_avail),
		.head_i(rdh_fb_o),
		.recv_en_o(recv_en),
		.frame_done_i(frame_done),
		.frame_bytes_i(frame_bytes),
		.cmd_o(cmd),
		.cmd_valid_o(cmd_valid),
		.cmd_ready_i(cmd_ready),
		.stat_word_o(stat_word),
		.wr_done_i(wr_done),
		.adv_o(adv)
	);

	rx_bus_writer #(
		.BUF_DWORDS(BUF_DWORDS),
		.MAX_BURST(MAX_BURST)
	) rx_bus_writer_i (
		.aclk(aclk),
		.arst_n_i(arst_n_i),
		.cmd_i(cmd),
		.cmd_valid_i(cmd_valid),
		.cmd_ready_o(cmd_ready),
		.stat_word_i(stat_word),
		.rd_idx_o(rd_idx),
		.rd_data_i(rd_data),
		.done_o(wr_done),
		.aw_o(axi_m_aw_o),
		.aw_valid_o(axi_m_awvalid_o),
		.aw_ready_i(axi_m_awready_i),
		.w_o(axi_m_w_o),
		.w_valid_o(axi_m_wvalid_o),
		.w_ready_i(axi_m_wready_i),
		.bvalid_i(axi_m_bvalid_i),
		.bready_o(axi_m_bready_o)
	);

	rx_intr_timer #(
		.TICK_CYCLES(TICK_CYCLES)
	) rx_intr_timer_i (
		.aclk(aclk),
		.arst_n_i(arst_n_i),
		.rdtr_i(cfg_i.rdtr),
		.start_i(adv),
		.rxt0_req_o(rxt0_req_o)
	);

endmodule

// File: logic/rx_pkg.sv
package rx_pkg;

	localparam int DATA_W = 32;
	localparam int DESC_BYTES = 16;
	localparam int STAT_OFFSET = 8; // Status dword inside a descriptor

	typedef logic [63:0] host_addr_t;
	typedef logic [DATA_W-1:0] dword_t;
	typedef logic [DATA_W/8-1:0] strb_t;
	typedef logic [15:0] byte_cnt_t;
	typedef logic [15:0] ring_idx_t;
	typedef logic [7:0] burst_len_t; // Beats minus one

	typedef struct packed {
		logic en;
		logic [1:0] bsize; // 0: 2048 down to 3: 256 bytes
		logic [1:0] rdmts;
		host_addr_t rdba;
		host_addr_t buf_base;
		logic [12:0] rdlen; // Units of 8 descriptors
		logic [15:0] rdtr;
	} rx_cfg_t;

	typedef struct packed {
		dword_t data;
		strb_t keep;
		logic last;
	} mac_beat_t;

	typedef struct packed {
		host_addr_t addr;
		burst_len_t len;
	} wr_addr_t;

	typedef struct packed {
		dword_t data;
		strb_t strb;
		logic last;
	} wr_data_t;

	// from_buf low selects the status dword
	typedef struct packed {
		host_addr_t addr;
		byte_cnt_t bytes;
		logic from_buf;
	} wr_cmd_t;

	typedef enum logic [2:0] {ST_IDLE, ST_RECV, ST_DATA, ST_STAT, ST_ADV} rx_state_e;

endpackage

// File: logic/rx_ring_ctrl.sv
module rx_ring_ctrl (
	input  logic aclk,
	input  logic arst_n_i,
	input  rx_pkg::rx_cfg_t cfg_i,
	input  rx_pkg::ring_idx_t rdh_i,
	input  rx_pkg::ring_idx_t rdt_i,
	input  logic rdh_set_i,
	input  logic rdt_set_i,
	input  logic adv_i,
	output logic slot_avail_o,
	output rx_pkg::ring_idx_t head_o,
	output logic rxdmt0_req_o
);
	import rx_pkg::*;

	ring_idx_t ring_size;
	ring_idx_t tail;
	ring_idx_t head_inc;
	ring_idx_t free_cnt;
	ring_idx_t min_thr;
	logic adv_q;

	assign ring_size = {cfg_i.rdlen, 3'b000};
	assign head_inc = head_o + 16'd1;
	assign free_cnt = (tail >= head_o) ? tail - head_o : tail + ring_size - head_o;
	assign min_thr = ring_size >> ({1'b0, cfg_i.rdmts} + 3'd1);
	assign slot_avail_o = (free_cnt != '0);

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			head_o <= '0;
			tail <= '0;
		end
		else
		begin
			if (rdh_set_i)
				head_o <= rdh_i;
			else if (adv_i)
				head_o <= (head_inc == ring_size) ? '0 : head_inc; // Wrap at ring end
			if (rdt_set_i)
				tail <= rdt_i;
		end
	end

	// Free count seen one cycle after the head moved
	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			adv_q <= 1'b0;
			rxdmt0_req_o <= 1'b0;
		end
		else
		begin
			adv_q <= adv_i;
			rxdmt0_req_o <= adv_q && (free_cnt <= min_thr);
		end
	end

endmodule

// File: rx_path.f
logic/rx_pkg.sv
logic/rx_ring_ctrl.sv
logic/rx_frame_buf.sv
logic/rx_bus_writer.sv
logic/rx_intr_timer.sv
logic/rx_engine.sv
logic/rx_path.sv
sim/rx_host_mem.sv
sim/rx_path_tb.sv

// File: sim/rx_host_mem.sv
module rx_host_mem #(
	parameter int MEM_BYTES = 65536
)(
	input  logic aclk,
	input  logic arst_n_i,
	input  rx_pkg::wr_addr_t aw_i,
	input  logic aw_valid_i,
	output logic aw_ready_o,
	input  rx_pkg::wr_data_t w_i,
	input  logic w_valid_i,
	output logic w_ready_o,
	output logic [1:0] bresp_o,
	output logic bvalid_o,
	input  logic bready_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import rx_pkg::*;

	logic [7:0] mem [MEM_BYTES];
	host_addr_t burst_addr [$]; // Bursts whose address phase is done
	host_addr_t beat_addr;
	int beat_cnt;
	int resp_cnt; // Bursts complete but not yet answered
	logic b_hs;
	logic [31:0] lfsr;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [7:0] fill_byte(input int unsigned a);
		return a[7:0] ^ a[15:8] ^ 8'h5a;
	endfunction

	initial
	begin
		for (int i = 0; i < MEM_BYTES; i++)
			mem[i] = fill_byte(i);
	end

	assign bresp_o = 2'b00;

	always @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			aw_ready_o <= 1'b0;
			w_ready_o <= 1'b0;
			bvalid_o <= 1'b0;
			lfsr = 32'h73341bf4;
			beat_cnt = 0;
			resp_cnt = 0;
			burst_addr.delete();
		end
		else
		begin
			if (aw_valid_i && aw_ready_o)
				burst_addr.push_back(aw_i.addr);
			if (w_valid_i && w_ready_o && (burst_addr.size() != 0))
			begin
				beat_addr = burst_addr[0] + host_addr_t'(beat_cnt * 4);
				for (int j = 0; j < 4; j++)
					if (w_i.strb[j] && (beat_addr + j < MEM_BYTES))
						mem[beat_addr + j] = w_i.data[8*j +: 8];
				beat_cnt++;
				if (w_i.last)
				begin
					void'(burst_addr.pop_front());
					beat_cnt = 0;
					resp_cnt++;
				end
			end
			b_hs = bvalid_o && bready_i;
			if (b_hs)
				resp_cnt--;
			lfsr = lfsr_next(lfsr);
			aw_ready_o <= lfsr[0];
			lfsr = lfsr_next(lfsr);
			w_ready_o <= lfsr[0];
			if (bvalid_o && !b_hs)
				bvalid_o <= 1'b1; // Held until taken
			else
			begin
				lfsr = lfsr_next(lfsr);
				bvalid_o <= (resp_cnt > 0) && lfsr[0];
			end
		end
	end

endmodule

// File: sim/rx_path_tb.sv
module rx_path_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rx_pkg::*;

	localparam int TICK_CYCLES = 4;
	localparam int MAX_BURST = 64;
	localparam int MEM_BYTES = 65536;
	localparam int STIM_WORDS = 256;
	localparam int WAIT_LIMIT = 20000;
	localparam int HOLD_CYCLES = 60; // Window in which a blocked beat must stay waiting

	logic aclk;
	logic arst_n;
	mac_beat_t mac_beat;
	logic mac_valid;
	logic mac_ready;
	rx_cfg_t cfg;
	ring_idx_t rdh;
	logic rdh_set;
	ring_idx_t rdt;
	logic rdt_set;
	ring_idx_t rdh_fb;
	wr_addr_t aw;
	logic aw_valid;
	logic aw_ready;
	wr_data_t w;
	logic w_valid;
	logic w_ready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic rxt0_req;
	logic rxdmt0_req;

	dword_t stim [STIM_WORDS];
	logic [7:0] exp_mem [MEM_BYTES]; // Shadow of host memory
	ring_idx_t exp_head;
	ring_idx_t exp_tail;
	logic [31:0] lfsr;
	int frame_cnt;

	rx_path #(
		.BUF_DWORDS(512),
		.MAX_BURST(MAX_BURST),
		.TICK_CYCLES(TICK_CYCLES)
	) DUT (
		.aclk(aclk),
		.arst_n_i(arst_n),
		.mac_s_i(mac_beat),
		.mac_s_tvalid_i(mac_valid),
		.mac_s_tready_o(mac_ready),
		.cfg_i(cfg),
		.rdh_i(rdh),
		.rdh_set_i(rdh_set),
		.rdt_i(rdt),
		.rdt_set_i(rdt_set),
		.rdh_fb_o(rdh_fb),
		.axi_m_aw_o(aw),
		.axi_m_awvalid_o(aw_valid),
		.axi_m_awready_i(aw_ready),
		.axi_m_w_o(w),
		.axi_m_wvalid_o(w_valid),
		.axi_m_wready_i(w_ready),
		.axi_m_bresp_i(bresp),
		.axi_m_bvalid_i(bvalid),
		.axi_m_bready_o(bready),
		.rxt0_req_o(rxt0_req),
		.rxdmt0_req_o(rxdmt0_req)
	);

	rx_host_mem #(
		.MEM_BYTES(MEM_BYTES)
	) host_mem (
		.aclk(aclk),
		.arst_n_i(arst_n),
		.aw_i(aw),
		.aw_valid_i(aw_valid),
		.aw_ready_o(aw_ready),
		.w_i(w),
		.w_valid_i(w_valid),
		.w_ready_o(w_ready),
		.bresp_o(bresp),
		.bvalid_o(bvalid),
		.bready_i(bready)
	);

	initial
	begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	task automatic stop_run();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic fail_plain(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic check_dword(input string name, input dword_t got, input dword_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_idx(input string name, input ring_idx_t got, input ring_idx_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic random_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b = lfsr[0];
	endtask

	function automatic logic [7:0] fill_byte(input int unsigned a);
		return a[7:0] ^ a[15:8] ^ 8'h5a;
	endfunction

	// Frame byte i carries fill + i with the lowest address in lane 0
	task automatic put_beat(input int bytes, input logic [7:0] fill, input int b);
		int left;
		left = bytes - 4 * b;
		for (int j = 0; j < 4; j++)
			mac_beat.data[8*j +: 8] = fill + 8'(4 * b + j);
		mac_beat.keep = (left >= 4) ? 4'hf : strb_t'((1 << left) - 1);
		mac_beat.last = (left <= 4);
		mac_valid = 1'b1;
	endtask

	task automatic send_frame(input int bytes, input logic [7:0] fill);
		int beats;
		int waited;
		int gaps;
		logic gap;
		beats = (bytes + 3) / 4;
		for (int b = 0; b < beats; b++)
		begin
			if (b != 0)
			begin
				gaps = 0;
				random_bit(gap);
				while (gap && (gaps < 3))
				begin
					mac_valid = 1'b0;
					@(negedge aclk);
					gaps++;
					random_bit(gap);
				end
			end
			put_beat(bytes, fill, b);
			waited = 0;
			while (!mac_ready)
			begin
				@(negedge aclk);
				waited++;
				if (waited > WAIT_LIMIT)
					fail_plain("MAC beat was not accepted in time");
			end
			@(negedge aclk); // Taken on the rising edge in between
		end
		mac_valid = 1'b0;
	endtask

	task automatic expect_blocked(input int bytes, input logic [7:0] fill);
		put_beat(bytes, fill, 0);
		for (int c = 0; c < HOLD_CYCLES; c++)
		begin
			if (mac_ready)
				fail_plain("MAC beat accepted with no free slot or the receiver disabled");
			@(negedge aclk);
		end
		check_idx("rdh_fb_o", rdh_fb, exp_head);
	endtask

	task automatic compare_region(input int unsigned start, input int len);
		for (int unsigned a = start; a < start + len; a++)
			check_byte($sformatf("host byte %h", a), host_mem.mem[a], exp_mem[a]);
	endtask

	task automatic run_frame(input int bytes, input logic [7:0] fill, input dword_t status);
		int size;
		int buf_bytes;
		int wr_bytes;
		int waited;
		int delay;
		int unsigned base;
		int unsigned desc;
		ring_idx_t slot;
		ring_idx_t next_head;
		logic dmt_exp;
		dword_t got;
		size = int'(cfg.rdlen) * 8;
		buf_bytes = 2048 >> cfg.bsize;
		wr_bytes = (bytes > buf_bytes) ? buf_bytes : bytes;
		slot = exp_head;
		next_head = (int'(slot) + 1 == size) ? '0 : slot + 16'd1;
		dmt_exp = ((int'(exp_tail) + size - int'(next_head)) % size) <= (size >> (cfg.rdmts + 1));
		delay = int'(cfg.rdtr) * TICK_CYCLES + 1;
		send_frame(bytes, fill);
		waited = 0;
		while (rdh_fb == slot)
		begin
			check_flag("rxt0_req_o", rxt0_req, 1'b0);
			check_flag("rxdmt0_req_o", rxdmt0_req, 1'b0);
			@(negedge aclk);
			waited++;
			if (waited > WAIT_LIMIT)
				fail_plain("head did not advance after a frame");
		end
		check_idx("rdh_fb_o", rdh_fb, next_head);
		exp_head = next_head;
		// Cycle 0 is the first one showing the new head
		for (int c = 0; c <= delay + 2; c++)
		begin
			check_flag("rxdmt0_req_o", rxdmt0_req, dmt_exp && (c == 1));
			check_flag("rxt0_req_o", rxt0_req, c == delay);
			@(negedge aclk);
		end
		base = cfg.buf_base[31:0] + slot * buf_bytes;
		for (int i = 0; i < wr_bytes; i++)
			exp_mem[base + i] = fill + 8'(i);
		desc = cfg.rdba[31:0] + slot * DESC_BYTES;
		for (int j = 0; j < 4; j++)
			exp_mem[desc + STAT_OFFSET + j] = status[8*j +: 8];
		for (int j = 0; j < 4; j++)
			got[8*j +: 8] = host_mem.mem[desc + STAT_OFFSET + j];
		check_dword("status dword", got, status);
		compare_region(base, buf_bytes);
		compare_region(desc, DESC_BYTES);
		frame_cnt++;
	endtask

	initial
	begin
		int pos;
		logic done;
		dword_t op;
		arst_n = 1'b0;
		mac_beat = '0;
		mac_valid = 1'b0;
		cfg = '0;
		rdh = '0;
		rdh_set = 1'b0;
		rdt = '0;
		rdt_set = 1'b0;
		lfsr = 32'h73341bf4;
		exp_head = '0;
		exp_tail = '0;
		frame_cnt = 0;
		for (int i = 0; i < STIM_WORDS; i++)
			stim[i] = 'x;
		for (int a = 0; a < MEM_BYTES; a++)
			exp_mem[a] = fill_byte(a);
		$readmemh("sim/rx_stimulus.txt", stim);
		repeat (4) @(negedge aclk);
		arst_n = 1'b1;
		@(negedge aclk);
		check_flag("mac_s_tready_o", mac_ready, 1'b0);
		check_flag("axi_m_awvalid_o", aw_valid, 1'b0);
		check_flag("axi_m_wvalid_o", w_valid, 1'b0);
		check_flag("rxt0_req_o", rxt0_req, 1'b0);
		check_flag("rxdmt0_req_o", rxdmt0_req, 1'b0);
		check_idx("rdh_fb_o", rdh_fb, '0);

		pos = 0;
		done = 1'b0;
		while (!done)
		begin
			op = stim[pos];
			case (op)
				32'h0:
					done = 1'b1;
				32'h1:
				begin
					cfg.en = stim[pos+1][0];
					cfg.bsize = stim[pos+2][1:0];
					cfg.rdmts = stim[pos+3][1:0];
					cfg.rdlen = stim[pos+4][12:0];
					cfg.rdtr = stim[pos+5][15:0];
					cfg.rdba = host_addr_t'(stim[pos+6]);
					cfg.buf_base = host_addr_t'(stim[pos+7]);
					@(negedge aclk);
					pos += 8;
				end
				32'h2:
				begin
					rdt = stim[pos+1][15:0];
					rdt_set = 1'b1;
					@(negedge aclk);
					rdt_set = 1'b0;
					exp_tail = rdt;
					pos += 2;
				end
				32'h3:
				begin
					run_frame(int'(stim[pos+1]), stim[pos+2][7:0], stim[pos+3]);
					pos += 4;
				end
				32'h4:
				begin
					expect_blocked(int'(stim[pos+1]), stim[pos+2][7:0]);
					pos += 3;
				end
				32'h5:
				begin
					rdh = stim[pos+1][15:0];
					rdh_set = 1'b1;
					@(negedge aclk);
					rdh_set = 1'b0;
					exp_head = rdh;
					check_idx("rdh_fb_o", rdh_fb, exp_head);
					pos += 2;
				end
				default:
					fail_plain("unknown record in the stimulus file");
			endcase
		end

		// Truncated tails and stray bursts would land outside the slots checked so far
		compare_region(0, MEM_BYTES);

		if (frame_cnt > 0)
		begin
			$display("Test OK");
			$finish;
		end
		else
			fail_plain("the stimulus file held no frame");
	end

endmodule

// File: sim/rx_stimulus.txt
// Records of hex words. 1 config: en bsize rdmts rdlen rdtr rdba buf_base
// 2 tail: rdt  3 frame: bytes fill status  4 blocked: bytes fill  5 head: rdh  0 end
1 0 0 0 1 1 0000c000 00008000
5 6
2 3
// Receiver off, the frame waits
4 3c 10
1 1 0 0 1 1 0000c000 00008000
3 3c 10 0003003c
// Head wraps from 7 to 0
3 5dc 33 000305dc
3 1 7f 00030001
1 1 0 1 1 2 0000c000 00008000
3 800 80 00030800
// One byte over the buffer
3 801 91 01030800
// Ring full, the frame waits for the tail write
1 1 3 2 1 0 0000c000 00008000
4 12c 21
2 7
3 12c 21 01030100
3 ff 44 000300ff
3 100 55 00030100
3 101 66 01030100
0
